//--- project.f
+incdir+common
common/spritePkg.sv
common/spriteIf.sv
rtl/obstacle/obstacleSprite.sv
rtl/heart/heartSprite.sv
rtl/spriteCompositor.sv
rtl/spriteLayer.sv
verification/spriteLayerChecks.sv
verification/spriteLayerTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = spriteLayerTb
FILELIST = project.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

//--- verification/spriteLayerTb.sv
`default_nettype none
`include "sprite_cfg.svh"

module spriteLayerTb;

	localparam int FrameCycles = 12;
	localparam int DriveDelay  = 10;
	localparam int IdleFrames  = 3;
	// score in window but cactus still right of centre
	localparam int EarlyFrames = 20;
	localparam int QuietFrames = 75;
	localparam int HeartFrames = 170;
	localparam int OverFrames  = 3;
	localparam int TotalFrames = IdleFrames + EarlyFrames + QuietFrames + HeartFrames + OverFrames;
	localparam int MaxCycles   = TotalFrames * FrameCycles + 40;

	logic                   frame_Clk;
	logic                   Reset;
	logic                   frameStart;
	spritePkg::gameStateT   gameState;
	spritePkg::scoreT       score;
	logic                   contact;
	spritePkg::coordT       writeX;
	spritePkg::coordT       writeY;
	logic [`ROM_ADDR_W-1:0] romAddress;
	logic                   pixelOn;
	spritePkg::spriteSelT   spriteSel;
	spritePkg::coordT       heartPosX;
	spritePkg::coordT       cactusPosX;
	spritePkg::coordT       pteroPosX;
	logic                   errorSeen;
	int                     seed;
	int                     cycleCount = 0;
	int                     f;

	spriteLayer dut (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.frameStart (frameStart),
		.gameState  (gameState),
		.score      (score),
		.contact    (contact),
		.writeX     (writeX),
		.writeY     (writeY),
		.romAddress (romAddress),
		.pixelOn    (pixelOn),
		.spriteSel  (spriteSel),
		.heartPosX  (heartPosX),
		.cactusPosX (cactusPosX),
		.pteroPosX  (pteroPosX)
	);

	spriteLayerChecks checks (.*);

	initial
		frame_Clk = 1'b0;

	always #50 frame_Clk = ~frame_Clk;

	task automatic failRun();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic nextCycle();
		@(posedge frame_Clk);
		#DriveDelay;
	endtask

	// random pixel near the sprite rows, or one aimed into the heart box
	task automatic scanPixel(input bit aimHeart);
		int col;
		int row;
		if (aimHeart)
		begin
			col    = $unsigned($random(seed)) % `HEART2_W;
			row    = $unsigned($random(seed)) % `HEART2_H;
			writeX = spritePkg::coordT'(int'(heartPosX) + col);
			writeY = spritePkg::coordT'(`HEART_Y + row);
		end
		else
		begin
			writeX = spritePkg::coordT'($unsigned($random(seed)) % 700);
			writeY = spritePkg::coordT'(330 + $unsigned($random(seed)) % 120);
		end
	endtask

	task automatic runFrame(input bit aimHeart, input bit pulseContact);
		int i;
		frameStart = 1'b1;
		scanPixel(aimHeart);
		nextCycle();
		frameStart = 1'b0;
		for (i = 1; i < FrameCycles; i++)
		begin
			contact = pulseContact && (i == 5);
			scanPixel(aimHeart && (i % 2 == 1));
			nextCycle();
		end
		contact = 1'b0;
	endtask

	initial
	begin
		wait (errorSeen);
		failRun();
	end

	always @(posedge frame_Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MaxCycles)
		begin
			$display("timeout: run did not finish within %0d cycles", MaxCycles);
			failRun();
		end
	end

	initial
	begin
		seed       = 63410;
		Reset      = 1'b1;
		frameStart = 1'b0;
		gameState  = spritePkg::idle;
		score      = 16'd320;
		contact    = 1'b0;
		writeX     = '0;
		writeY     = '0;
		repeat (3) @(posedge frame_Clk);
		#DriveDelay;
		Reset = 1'b0;

		// nothing may move outside running
		repeat (IdleFrames) runFrame(1'b0, 1'b0);
		gameState = spritePkg::running;
		repeat (EarlyFrames) runFrame(1'b0, 1'b0);
		score = 16'd360;
		repeat (QuietFrames) runFrame(1'b0, 1'b0);

		// both obstacles left of centre by now, heart spawns
		score = 16'd320;
		for (f = 0; f < HeartFrames; f++)
			runFrame(1'b1, f == 80);

		gameState = spritePkg::over;
		repeat (OverFrames) runFrame(1'b1, 1'b0);
		nextCycle();

		if (errorSeen)
			failRun();
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verification/spriteLayerChecks.sv
`default_nettype none
`include "sprite_cfg.svh"

module spriteLayerChecks
(
	input  wire logic                    frame_Clk,
	input  wire logic                    Reset,
	input  wire logic                    frameStart,
	input  wire spritePkg::gameStateT    gameState,
	input  wire spritePkg::scoreT        score,
	input  wire logic                    contact,
	input  wire spritePkg::coordT        writeX,
	input  wire spritePkg::coordT        writeY,
	input  wire logic [`ROM_ADDR_W-1:0]  romAddress,
	input  wire logic                    pixelOn,
	input  wire spritePkg::spriteSelT    spriteSel,
	input  wire spritePkg::coordT        heartPosX,
	input  wire spritePkg::coordT        cactusPosX,
	input  wire spritePkg::coordT        pteroPosX,
	output logic                         errorSeen
);

	localparam int AddrW = `ROM_ADDR_W;

	// reference state of the sprite layer
	int  cacX;
	int  ptX;
	int  ptDelay;
	int  hX;
	bit  hActive;
	bit  hCollected;
	int  frames;
	bit  errorFlag = 1'b0;

	// expected pixel path, one cycle behind the scan
	bit                    secondImg;
	int                    heartW;
	int                    heartH;
	int                    heartBase;
	int                    px;
	int                    py;
	spritePkg::spriteSelT  nextSel;
	int                    nextAddr;
	logic                  expPixelOn;
	spritePkg::spriteSelT  expSel;
	logic [AddrW-1:0]      expAddr;

	assign errorSeen = errorFlag;

	function automatic bit inBox(int x, int y, int left, int top, int w, int h);
		return (x >= left) && (x < left + w) && (y >= top) && (y < top + h);
	endfunction

	function automatic bit spawnAllowed(int sc, int cx, int pterX);
		int inBlock;
		inBlock = sc % `SCORE_PERIOD;
		return (inBlock > `SCORE_LO) && (inBlock < `SCORE_HI) && (cx < `SCREEN_W / 2)
			&& ((pterX < `SCREEN_W / 2) || (pterX > `PTERO_FAR));
	endfunction

	task automatic reportMismatch(input string name, input int got, input int expected);
		$display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
		errorFlag = 1'b1;
	endtask

	always_comb
	begin
		// image flips after every ANIM_PERIOD frame strobes
		secondImg = ((frames / `ANIM_PERIOD) % 2) == 1;
		heartW    = secondImg ? `HEART2_W : `HEART1_W;
		heartH    = secondImg ? `HEART2_H : `HEART1_H;
		heartBase = secondImg ? `HEART2_BASE : `HEART1_BASE;
		px        = int'(writeX);
		py        = int'(writeY);
		nextSel   = spritePkg::none;
		nextAddr  = 0;
		if (hActive && !hCollected && inBox(px, py, hX, `HEART_Y, heartW, heartH))
		begin
			nextSel  = spritePkg::heart;
			nextAddr = heartBase + (py - `HEART_Y) * heartW + (px - hX);
		end
		else if (inBox(px, py, cacX, `CACTUS_Y, `CACTUS_W, `CACTUS_H))
		begin
			nextSel  = spritePkg::cactus;
			nextAddr = `CACTUS_BASE + (py - `CACTUS_Y) * `CACTUS_W + (px - cacX);
		end
		else if (inBox(px, py, ptX, `PTERO_Y, `PTERO_W, `PTERO_H))
		begin
			nextSel  = spritePkg::ptero;
			nextAddr = `PTERO_BASE + (py - `PTERO_Y) * `PTERO_W + (px - ptX);
		end
	end

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			cacX       <= `SCREEN_W;
			ptX        <= `SCREEN_W;
			ptDelay    <= `PTERO_DELAY;
			hX         <= `SCREEN_W;
			hActive    <= 1'b0;
			hCollected <= 1'b0;
			frames     <= 0;
			expPixelOn <= 1'b0;
			expSel     <= spritePkg::none;
			expAddr    <= '0;
		end
		else
		begin
			expPixelOn <= (nextSel != spritePkg::none);
			expSel     <= nextSel;
			expAddr    <= AddrW'(nextAddr);
			if (contact && hActive)
				hCollected <= 1'b1;
			if (frameStart)
				frames <= frames + 1;
			if (frameStart && (gameState == spritePkg::running))
			begin
				cacX <= (cacX < -`CACTUS_W) ? `SCREEN_W : cacX - `OBST_SPEED;
				if (ptDelay > 0)
					ptDelay <= ptDelay - 1;
				else if (ptX < -`PTERO_W)
				begin
					ptX     <= `SCREEN_W;
					ptDelay <= `PTERO_DELAY;
				end
				else
					ptX <= ptX - `OBST_SPEED;
				// heart leaves only once it has gone past the left edge
				if (hActive && (hX < 0))
				begin
					hX         <= `SCREEN_W;
					hActive    <= 1'b0;
					hCollected <= 1'b0;
				end
				else if (hActive || spawnAllowed(int'(score), cacX, ptX))
				begin
					hActive <= 1'b1;
					hX      <= hX - `HEART_SPEED;
				end
			end
		end
	end

	assert property (@(posedge frame_Clk) $fell(Reset) |-> !pixelOn)
		else reportMismatch("pixelOn after reset", $sampled(pixelOn), 0);

	assert property (@(posedge frame_Clk) $fell(Reset) |-> (spriteSel == spritePkg::none))
		else reportMismatch("spriteSel after reset", $sampled(spriteSel),
			int'(spritePkg::none));

	assert property (@(posedge frame_Clk) disable iff (Reset) int'(cactusPosX) == cacX)
		else reportMismatch("cactusPosX", $sampled(cactusPosX), $sampled(cacX));

	assert property (@(posedge frame_Clk) disable iff (Reset) int'(pteroPosX) == ptX)
		else reportMismatch("pteroPosX", $sampled(pteroPosX), $sampled(ptX));

	assert property (@(posedge frame_Clk) disable iff (Reset) int'(heartPosX) == hX)
		else reportMismatch("heartPosX", $sampled(heartPosX), $sampled(hX));

	assert property (@(posedge frame_Clk) disable iff (Reset) pixelOn == expPixelOn)
		else reportMismatch("pixelOn", $sampled(pixelOn), $sampled(expPixelOn));

	assert property (@(posedge frame_Clk) disable iff (Reset) spriteSel == expSel)
		else reportMismatch("spriteSel", $sampled(spriteSel), $sampled(expSel));

	assert property (@(posedge frame_Clk) disable iff (Reset)
		expPixelOn |-> romAddress == expAddr)
		else reportMismatch("romAddress", $sampled(romAddress), $sampled(expAddr));

endmodule

`default_nettype wire

//--- rtl/spriteLayer.sv
`default_nettype none
`include "sprite_cfg.svh"

module spriteLayer
(
	input  wire logic                 frame_Clk,
	input  wire logic                 Reset,
	input  wire logic                 frameStart,
	input  wire spritePkg::gameStateT gameState,
	input  wire spritePkg::scoreT     score,
	input  wire logic                 contact,
	input  wire spritePkg::coordT     writeX,
	input  wire spritePkg::coordT     writeY,
	output logic [`ROM_ADDR_W-1:0]    romAddress,
	output logic                      pixelOn,
	output spritePkg::spriteSelT      spriteSel,
	output spritePkg::coordT          heartPosX,
	output spritePkg::coordT          cactusPosX,
	output spritePkg::coordT          pteroPosX
);

	spriteIf heartBus ();
	spriteIf cactusBus ();
	spriteIf pteroBus ();

	obstacleSprite #(
		.BASE          (`CACTUS_BASE),
		.WIDTH         (`CACTUS_W),
		.HEIGHT        (`CACTUS_H),
		.ROW_Y         (`CACTUS_Y),
		.RESPAWN_DELAY (`CACTUS_DELAY)
	) cactusObst (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.frameStart (frameStart),
		.gameState  (gameState),
		.writeX     (writeX),
		.writeY     (writeY),
		.sprite     (cactusBus.source)
	);

	// pterosaur holds off at start so the two obstacles stay apart
	obstacleSprite #(
		.BASE          (`PTERO_BASE),
		.WIDTH         (`PTERO_W),
		.HEIGHT        (`PTERO_H),
		.ROW_Y         (`PTERO_Y),
		.RESPAWN_DELAY (`PTERO_DELAY)
	) pteroObst (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.frameStart (frameStart),
		.gameState  (gameState),
		.writeX     (writeX),
		.writeY     (writeY),
		.sprite     (pteroBus.source)
	);

	heartSprite heartSpr (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.frameStart (frameStart),
		.gameState  (gameState),
		.score      (score),
		.contact    (contact),
		.cactusPosX (cactusBus.posX),
		.pteroPosX  (pteroBus.posX),
		.writeX     (writeX),
		.writeY     (writeY),
		.sprite     (heartBus.source)
	);

	spriteCompositor compositor (
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.heart      (heartBus.sink),
		.cactus     (cactusBus.sink),
		.ptero      (pteroBus.sink),
		.romAddress (romAddress),
		.pixelOn    (pixelOn),
		.spriteSel  (spriteSel)
	);

	assign heartPosX  = heartBus.posX;
	assign cactusPosX = cactusBus.posX;
	assign pteroPosX  = pteroBus.posX;

endmodule

`default_nettype wire

//--- rtl/spriteCompositor.sv
`default_nettype none
`include "sprite_cfg.svh"

module spriteCompositor
(
	input  wire logic                    frame_Clk,
	input  wire logic                    Reset,
	spriteIf.sink                        heart,
	spriteIf.sink                        cactus,
	spriteIf.sink                        ptero,
	output logic [`ROM_ADDR_W-1:0]       romAddress,
	output logic                         pixelOn,
	output spritePkg::spriteSelT         spriteSel
);

	spritePkg::spriteSelT    winSel;
	logic [`ROM_ADDR_W-1:0]  winAddress;

	// fixed priority, heart drawn over everything
	always_comb
	begin
		winSel     = spritePkg::none;
		winAddress = '0;
		if (heart.hit)
		begin
			winSel     = spritePkg::heart;
			winAddress = heart.address;
		end
		else if (cactus.hit)
		begin
			winSel     = spritePkg::cactus;
			winAddress = cactus.address;
		end
		else if (ptero.hit)
		begin
			winSel     = spritePkg::ptero;
			winAddress = ptero.address;
		end
	end

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			pixelOn   <= 1'b0;
			spriteSel <= spritePkg::none;
		end
		else
		begin
			pixelOn   <= heart.hit || cactus.hit || ptero.hit;
			spriteSel <= winSel;
		end
	end

	// address goes straight to the ROM
	always_ff @(posedge frame_Clk)
	begin
		romAddress <= winAddress;
	end

	assert property (@(posedge frame_Clk) disable iff (Reset)
		pixelOn == (spriteSel != spritePkg::none));

endmodule

`default_nettype wire

//--- rtl/heart/heartSprite.sv
`default_nettype none
`include "sprite_cfg.svh"

module heartSprite
(
	input  wire logic                 frame_Clk,
	input  wire logic                 Reset,
	input  wire logic                 frameStart,
	input  wire spritePkg::gameStateT gameState,
	input  wire spritePkg::scoreT     score,
	input  wire logic                 contact,
	input  wire spritePkg::coordT     cactusPosX,
	input  wire spritePkg::coordT     pteroPosX,
	input  wire spritePkg::coordT     writeX,
	input  wire spritePkg::coordT     writeY,
	spriteIf.source                   sprite
);

	localparam int AddrW      = `ROM_ADDR_W;
	localparam int AnimPeriod = `ANIM_PERIOD;
	localparam int CntW       = $clog2(AnimPeriod + 1);

	spritePkg::coordT     posX;
	logic                 active;
	logic                 collected;
	logic [CntW-1:0]      frameCnt;
	logic                 drawFirst;
	spritePkg::scoreT     scoreInBlock;
	logic                 spawnOk;
	logic                 isRunning;
	logic [AddrW-1:0]     imgBase;
	spritePkg::coordT     imgW;
	spritePkg::coordT     imgH;
	spritePkg::coordT     dx;
	spritePkg::coordT     dy;

	assign isRunning    = (gameState == spritePkg::running);
	assign scoreInBlock = score % spritePkg::scoreT'(`SCORE_PERIOD);

	// spawn only in the score window and when the obstacles leave room
	assign spawnOk = (scoreInBlock > `SCORE_LO) && (scoreInBlock < `SCORE_HI)
		&& (cactusPosX < (`SCREEN_W / 2))
		&& ((pteroPosX < (`SCREEN_W / 2)) || (pteroPosX > `PTERO_FAR));

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			posX      <= spritePkg::coordT'(`SCREEN_W);
			active    <= 1'b0;
			collected <= 1'b0;
		end
		else
		begin
			// player touched it, hide until it goes idle
			if (contact && active)
				collected <= 1'b1;
			if (frameStart && isRunning)
			begin
				if (active)
				begin
					if (posX < 0)
					begin
						posX      <= spritePkg::coordT'(`SCREEN_W);
						active    <= 1'b0;
						collected <= 1'b0;
					end
					else
						posX <= posX - spritePkg::coordT'(`HEART_SPEED);
				end
				else if (spawnOk)
				begin
					active <= 1'b1;
					posX   <= posX - spritePkg::coordT'(`HEART_SPEED);
				end
			end
		end
	end

	// animation runs on every frame regardless of game state
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			frameCnt  <= CntW'(1);
			drawFirst <= 1'b1;
		end
		else if (frameStart)
		begin
			if (frameCnt == CntW'(AnimPeriod))
			begin
				frameCnt  <= CntW'(1);
				drawFirst <= ~drawFirst;
			end
			else
				frameCnt <= frameCnt + CntW'(1);
		end
	end

	always_comb
	begin
		if (drawFirst)
		begin
			imgBase = AddrW'(`HEART1_BASE);
			imgW    = spritePkg::coordT'(`HEART1_W);
			imgH    = spritePkg::coordT'(`HEART1_H);
		end
		else
		begin
			imgBase = AddrW'(`HEART2_BASE);
			imgW    = spritePkg::coordT'(`HEART2_W);
			imgH    = spritePkg::coordT'(`HEART2_H);
		end
	end

	assign sprite.posX = posX;
	assign sprite.posY = spritePkg::coordT'(`HEART_Y);

	assign dx = writeX - sprite.posX;
	assign dy = writeY - sprite.posY;

	assign sprite.hit = active && !collected && (dx >= 0) && (dx < imgW)
		&& (dy >= 0) && (dy < imgH);
	// row major within the current image
	assign sprite.address = imgBase + AddrW'(dy) * AddrW'(imgW) + AddrW'(dx);

	// idle heart parks at the right edge and never shows
	assert property (@(posedge frame_Clk) disable iff (Reset)
		!active |-> (sprite.posX == `SCREEN_W) && !sprite.hit);

	assert property (@(posedge frame_Clk) disable iff (Reset)
		(frameCnt >= CntW'(1)) && (frameCnt <= CntW'(AnimPeriod)));

endmodule

`default_nettype wire

//--- rtl/obstacle/obstacleSprite.sv
`default_nettype none
`include "sprite_cfg.svh"

module obstacleSprite
#(
	parameter int BASE          = `CACTUS_BASE,
	parameter int WIDTH         = `CACTUS_W,
	parameter int HEIGHT        = `CACTUS_H,
	parameter int ROW_Y         = `CACTUS_Y,
	parameter int RESPAWN_DELAY = `CACTUS_DELAY
)
(
	input  wire logic                 frame_Clk,
	input  wire logic                 Reset,
	input  wire logic                 frameStart,
	input  wire spritePkg::gameStateT gameState,
	input  wire spritePkg::coordT     writeX,
	input  wire spritePkg::coordT     writeY,
	spriteIf.source                   sprite
);

	localparam int AddrW = `ROM_ADDR_W;

	spritePkg::coordT posX;
	// frames left before the obstacle starts scrolling again
	logic [7:0]       delayCnt;
	spritePkg::coordT dx;
	spritePkg::coordT dy;
	logic [AddrW-1:0] offset;

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			posX     <= spritePkg::coordT'(`SCREEN_W);
			delayCnt <= 8'(RESPAWN_DELAY);
		end
		else if (frameStart && (gameState == spritePkg::running))
		begin
			if (delayCnt != 8'd0)
				delayCnt <= delayCnt - 8'd1;
			else if (posX < -spritePkg::coordT'(WIDTH))
			begin
				// fully off the left edge, wrap back to the right
				posX     <= spritePkg::coordT'(`SCREEN_W);
				delayCnt <= 8'(RESPAWN_DELAY);
			end
			else
				posX <= posX - spritePkg::coordT'(`OBST_SPEED);
		end
	end

	assign sprite.posX = posX;
	assign sprite.posY = spritePkg::coordT'(ROW_Y);

	// pixel offset relative to the sprite's top left corner
	assign dx = writeX - sprite.posX;
	assign dy = writeY - sprite.posY;

	assign sprite.hit = (dx >= 0) && (dx < spritePkg::coordT'(WIDTH))
		&& (dy >= 0) && (dy < spritePkg::coordT'(HEIGHT));

	assign offset         = AddrW'(dy) * AddrW'(WIDTH) + AddrW'(dx);
	assign sprite.address = AddrW'(BASE) + offset;

	assert property (@(posedge frame_Clk) disable iff (Reset)
		sprite.posX <= `SCREEN_W);

endmodule

`default_nettype wire

//--- common/spriteIf.sv
`default_nettype none
`include "sprite_cfg.svh"

// one sprite's view of the scanned pixel plus its position
interface spriteIf;

	logic                     hit;
	logic [`ROM_ADDR_W-1:0]   address;
	spritePkg::coordT         posX;
	spritePkg::coordT         posY;

	// driven by the sprite block
	modport source
	(
		output hit,
		output address,
		output posX,
		output posY
	);

	// read by the compositor
	modport sink
	(
		input hit,
		input address,
		input posX,
		input posY
	);

endinterface

`default_nettype wire

//--- common/spritePkg.sv
`default_nettype none

package spritePkg;

	// game FSM state as driven by the game controller
	typedef enum logic [1:0]
	{
		idle    = 2'd0,
		running = 2'd1,
		over    = 2'd2
	} gameStateT;

	// signed so sprites can sit partly off the left edge
	typedef logic signed [10:0] coordT;

	typedef logic [15:0] scoreT;

	// which sprite owns the current pixel
	typedef enum logic [1:0]
	{
		none   = 2'd0,
		heart  = 2'd1,
		cactus = 2'd2,
		ptero  = 2'd3
	} spriteSelT;

endpackage

`default_nettype wire

//--- common/sprite_cfg.svh
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// playfield
`define SCREEN_W      640

// sprite rows, top edge in screen lines
`define HEART_Y       392
`define CACTUS_Y      400
`define PTERO_Y       350

// heart images, two animation frames
`define HEART1_BASE   224411
`define HEART2_BASE   224717
`define HEART1_W      18
`define HEART1_H      17
`define HEART2_W      18
`define HEART2_H      19

// obstacle images
`define CACTUS_BASE   200000
`define CACTUS_W      24
`define CACTUS_H      40
`define PTERO_BASE    210000
`define PTERO_W       46
`define PTERO_H       40

// motion in pixels per frame
`define HEART_SPEED   4
`define OBST_SPEED    6

// frames per heart image
`define ANIM_PERIOD   10

// heart spawn window, repeats every SCORE_PERIOD points
`define SCORE_PERIOD  1000
`define SCORE_LO      300
`define SCORE_HI      350

`define PTERO_FAR     670
`define PTERO_DELAY   40
`define CACTUS_DELAY  0

`define ROM_ADDR_W    18

`endif
